// ==== source/board_map_pkg.sv ====
package board_map_pkg;

    // Region base byte addresses
    localparam logic [15:0] rom_base = 16'h0000;
    localparam logic [15:0] ram_base = 16'h0400;

    // Both memories are 1 KB deep
    localparam int mem_words = 256;

    // Memory page numbers, address bits above the 1 KB region
    localparam logic [5:0] rom_page = rom_base[15:10];
    localparam logic [5:0] ram_page = ram_base[15:10];

    // I/O page sits at 0x1000, address bits above the low four
    localparam logic [11:0] io_page = 12'h100;

    // Register numbers inside the I/O page
    localparam logic [1:0] key_reg  = 2'd0;
    localparam logic [1:0] uart_reg = 2'd1;

    // Program memory image
    localparam string rom_file = "rom.hex";

    // Target of the current transfer
    typedef enum logic [2:0] {
        sel_none = 3'd0,
        sel_rom  = 3'd1,
        sel_ram  = 3'd2,
        sel_key  = 3'd3,
        sel_uart = 3'd4
    } target_t;

endpackage

// ==== source/bus_pkg.sv ====
package bus_pkg;

    // APB widths
    localparam int addr_w = 16;
    localparam int data_w = 32;

    // Memory view, page then word index then byte offset
    typedef struct packed {
        logic [5:0] page;
        logic [7:0] index;
        logic [1:0] offset;
    } mem_addr_t;

    // I/O view, page then register number then byte offset
    typedef struct packed {
        logic [11:0] page;
        logic [1:0]  reg_num;
        logic [1:0]  offset;
    } io_addr_t;

    // One address word, read either way
    typedef union packed {
        mem_addr_t mem;
        io_addr_t  io;
    } bus_addr_u;

endpackage

// ==== source/bus_decode.sv ====
`timescale 1ns/1ns

module bus_decode
    import bus_pkg::*;
    import board_map_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic [addr_w-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    output logic              start,
    output target_t           target,
    output logic              write
);

    bus_addr_u addr;
    target_t   target_next;
    logic      setup;

    assign addr = paddr;

    // Setup phase, selected but not yet enabled
    assign setup = psel && !penable;

    // Region select from both views of the address
    always_comb begin
        target_next = sel_none;
        if (addr.mem.page == rom_page && addr.mem.offset == 2'b00) begin
            target_next = sel_rom;
        end else if (addr.mem.page == ram_page && addr.mem.offset == 2'b00) begin
            target_next = sel_ram;
        end else if (addr.io.page == io_page && addr.io.offset == 2'b00) begin
            // Only two registers live in the I/O page
            if (addr.io.reg_num == key_reg) begin
                target_next = sel_key;
            end else if (addr.io.reg_num == uart_reg) begin
                target_next = sel_uart;
            end
        end
    end

    // Capture once per transfer at the end of setup
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            start  <= 1'b0;
            target <= sel_none;
            write  <= 1'b0;
        end else begin
            start <= setup;
            if (setup) begin
                target <= target_next;
                write  <= pwrite;
            end
        end
    end

endmodule

// ==== source/mem_execute.sv ====
`timescale 1ns/1ns

module mem_execute
    import bus_pkg::*;
    import board_map_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              start,
    input  target_t           target,
    input  logic              write,
    input  logic [addr_w-1:0] paddr,
    input  logic [data_w-1:0] pwdata,
    output logic [data_w-1:0] mem_rdata
);

    logic [data_w-1:0] rom_mem [mem_words];
    logic [data_w-1:0] ram_mem [mem_words];

    bus_addr_u addr;
    logic      ram_we;

    assign addr = paddr;

    // Only data memory is writable
    assign ram_we = start && write && (target == sel_ram);

    // Program memory, zero-filled and then loaded from the image
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            rom_mem[i] = '0;
        end
        $readmemh(rom_file, rom_mem);
    end

    // Synchronous read
    // Address is held from setup, so the word is ready right after the setup edge
    always_ff @(posedge CLOCK_50) begin
        if (addr.mem.page == ram_page) begin
            mem_rdata <= ram_mem[addr.mem.index];
        end else begin
            mem_rdata <= rom_mem[addr.mem.index];
        end
    end

    // Full word write, while address and data are still held
    always_ff @(posedge CLOCK_50) begin
        if (ram_we) begin
            ram_mem[addr.mem.index] <= pwdata;
        end
    end

endmodule

// ==== source/io_execute.sv ====
`timescale 1ns/1ns

module io_execute
    import bus_pkg::*;
    import board_map_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              start,
    input  target_t           target,
    input  logic              write,
    input  logic [data_w-1:0] pwdata,
    input  logic              key_valid,
    input  logic [7:0]        key_ascii,
    input  logic              irq_ack,
    output logic [data_w-1:0] key_rdata,
    output logic              irq,
    output logic              uart_valid,
    output logic [7:0]        uart_data
);

    logic [7:0] key_q;
    logic       key_hit;
    logic       uart_wr;

    // A zero code means no real key
    assign key_hit = key_valid && (key_ascii != 8'd0);

    // One strobe per UART write transfer
    assign uart_wr = start && write && (target == sel_uart);

    // Keyboard register reads back zero-extended
    assign key_rdata = {{(data_w - 8){1'b0}}, key_q};

    // Key latch and interrupt hold
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_q <= 8'd0;
            irq   <= 1'b0;
        end else begin
            if (key_hit) begin
                key_q <= key_ascii;
                // New key wins over an acknowledge in the same cycle
                irq   <= 1'b1;
            end else if (irq_ack) begin
                irq <= 1'b0;
            end
        end
    end

    // Transmit strobe
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_valid <= 1'b0;
        end else begin
            uart_valid <= uart_wr;
        end
    end

    // Low byte of the write goes out with the strobe
    always_ff @(posedge CLOCK_50) begin
        if (uart_wr) begin
            uart_data <= pwdata[7:0];
        end
    end

endmodule

// ==== source/bus_result.sv ====
`timescale 1ns/1ns

module bus_result
    import bus_pkg::*;
    import board_map_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              start,
    input  target_t           target,
    input  logic              write,
    input  logic [data_w-1:0] mem_rdata,
    input  logic [data_w-1:0] key_rdata,
    output logic [data_w-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    logic [data_w-1:0] rdata_sel;
    logic              err_sel;

    // Read data by target, zero for writes and for the UART
    always_comb begin
        rdata_sel = '0;
        if (!write) begin
            case (target)
                sel_rom, sel_ram: rdata_sel = mem_rdata;
                sel_key:          rdata_sel = key_rdata;
                default:          rdata_sel = '0;
            endcase
        end
    end

    // Unmapped space, or a store into program memory
    assign err_sel = (target == sel_none) || (write && target == sel_rom);

    // Completion one cycle after start, for one cycle only
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end else begin
            pready  <= start;
            pslverr <= start && err_sel;
            prdata  <= start ? rdata_sel : '0;
        end
    end

endmodule

// ==== source/board_bus_top.sv ====
`timescale 1ns/1ns

module board_bus_top
    import bus_pkg::*;
    import board_map_pkg::*;
(
    input  logic              CLOCK_50,
    input  logic              KEY0,
    // APB completer
    input  logic [addr_w-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [data_w-1:0] pwdata,
    output logic [data_w-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    // Keyboard and interrupt
    input  logic              key_valid,
    input  logic [7:0]        key_ascii,
    output logic              irq,
    input  logic              irq_ack,
    // UART transmit
    output logic              uart_valid,
    output logic [7:0]        uart_data
);

    logic              start;
    target_t           target;
    logic              write;
    logic [data_w-1:0] mem_rdata;
    logic [data_w-1:0] key_rdata;

    // Decode
    bus_decode u_decode (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .start    (start),
        .target   (target),
        .write    (write)
    );

    // Memories
    mem_execute u_mem (
        .CLOCK_50  (CLOCK_50),
        .start     (start),
        .target    (target),
        .write     (write),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .mem_rdata (mem_rdata)
    );

    // Keyboard, interrupt and UART
    io_execute u_io (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .start      (start),
        .target     (target),
        .write      (write),
        .pwdata     (pwdata),
        .key_valid  (key_valid),
        .key_ascii  (key_ascii),
        .irq_ack    (irq_ack),
        .key_rdata  (key_rdata),
        .irq        (irq),
        .uart_valid (uart_valid),
        .uart_data  (uart_data)
    );

    // Response
    bus_result u_result (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .start     (start),
        .target    (target),
        .write     (write),
        .mem_rdata (mem_rdata),
        .key_rdata (key_rdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

endmodule

// ==== tb/board_bus_model.svh ====
`ifndef BOARD_BUS_MODEL_SVH
`define BOARD_BUS_MODEL_SVH

// Shadow state of program memory, data memory and the key latch
logic [data_w-1:0] rom_ref [mem_words];
logic [data_w-1:0] ram_ref [mem_words];
logic [7:0]        key_ref;

// Zero fill, then the same image the board loads
task automatic load_model();
    for (int i = 0; i < mem_words; i++) begin
        rom_ref[i] = '0;
        ram_ref[i] = '0;
    end
    $readmemh(rom_file, rom_ref);
    key_ref = 8'd0;
endtask

// Device that answers a byte address, misaligned goes nowhere
function automatic target_t region_of(input logic [addr_w-1:0] a);
    if (a[1:0] != 2'b00) return sel_none;
    if (a[15:10] == rom_base[15:10]) return sel_rom;
    if (a[15:10] == ram_base[15:10]) return sel_ram;
    if (a[15:4] == io_page && a[3:2] == key_reg) return sel_key;
    if (a[15:4] == io_page && a[3:2] == uart_reg) return sel_uart;
    return sel_none;
endfunction

// Writes and UART reads return zero
function automatic logic [data_w-1:0] expected_rdata(input logic [addr_w-1:0] a,
                                                     input logic wr);
    if (wr) return '0;
    case (region_of(a))
        sel_rom: return rom_ref[a[9:2]];
        sel_ram: return ram_ref[a[9:2]];
        sel_key: return {24'd0, key_ref};
        default: return '0;
    endcase
endfunction

// Unmapped space, or a store into program memory
function automatic logic expected_err(input logic [addr_w-1:0] a, input logic wr);
    return (region_of(a) == sel_none) || (wr && region_of(a) == sel_rom);
endfunction

// Only data memory keeps a write
function automatic void store_shadow(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    if (region_of(a) == sel_ram) ram_ref[a[9:2]] = d;
endfunction

`endif

// ==== tb/board_bus_tb.sv ====
`timescale 1ns/1ns

module board_bus_tb
    import bus_pkg::*;
    import board_map_pkg::*;
();

    localparam logic [addr_w-1:0] key_addr  = {io_page, key_reg, 2'b00};
    localparam logic [addr_w-1:0] uart_addr = {io_page, uart_reg, 2'b00};

    logic              CLOCK_50;
    logic              KEY0;
    logic [addr_w-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [data_w-1:0] pwdata;
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              key_valid;
    logic [7:0]        key_ascii;
    logic              irq;
    logic              irq_ack;
    logic              uart_valid;
    logic [7:0]        uart_data;

    // Transfer in flight as handed from the driver to the checker
    logic              pend;
    logic [addr_w-1:0] pend_addr;
    logic              pend_write;
    logic [data_w-1:0] pend_data;
    int                pend_cycle;
    int                cycle;
    int                checks;
    int                errors;
    logic [7:0]        uart_exp [$];
    logic [7:0]        idx_list [$];

    `include "board_bus_model.svh"

    board_bus_top dut0 (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .key_valid  (key_valid),
        .key_ascii  (key_ascii),
        .irq        (irq),
        .irq_ack    (irq_ack),
        .uart_valid (uart_valid),
        .uart_data  (uart_data)
    );

    // 40 ns period
    always #20 CLOCK_50 = ~CLOCK_50;

    always @(posedge CLOCK_50) begin
        cycle <= cycle + 1;
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic close_run();
        $display("Responses checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic abort_run(input string msg);
        errors++;
        $display("Timeout: %s", msg);
        close_run();
    endtask

    // Setup cycle then access until pready
    // Inputs change 2 ns after the edge and pready is looked at mid-cycle
    task automatic apb_transfer(input logic [addr_w-1:0] a, input logic wr,
                                input logic [data_w-1:0] d);
        int n;
        @(posedge CLOCK_50);
        #2;
        paddr      = a;
        pwrite     = wr;
        pwdata     = d;
        psel       = 1'b1;
        penable    = 1'b0;
        pend_addr  = a;
        pend_write = wr;
        pend_data  = d;
        pend_cycle = cycle;
        pend       = 1'b1;
        @(posedge CLOCK_50);
        #2;
        penable = 1'b1;
        n = 0;
        @(negedge CLOCK_50);
        while (pready !== 1'b1 && n < 8) begin
            n++;
            @(negedge CLOCK_50);
        end
        if (pready !== 1'b1) begin
            abort_run($sformatf("no pready for address %h", a));
        end else begin
            // Transfer ends after the edge that sees pready
            @(posedge CLOCK_50);
            #2;
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic apb_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
        if (region_of(a) == sel_uart) uart_exp.push_back(d[7:0]);
        apb_transfer(a, 1'b1, d);
    endtask

    task automatic apb_read(input logic [addr_w-1:0] a);
        apb_transfer(a, 1'b0, '0);
    endtask

    // One-cycle key strobe
    // Value zero stands for no key
    task automatic press_key(input logic [7:0] code, input logic ack);
        @(posedge CLOCK_50);
        #2;
        key_valid = 1'b1;
        key_ascii = code;
        irq_ack   = ack;
        if (code != 8'd0) key_ref = code;
        @(posedge CLOCK_50);
        #2;
        key_valid = 1'b0;
        key_ascii = 8'd0;
        irq_ack   = 1'b0;
    endtask

    task automatic pulse_ack();
        @(posedge CLOCK_50);
        #2;
        irq_ack = 1'b1;
        @(posedge CLOCK_50);
        #2;
        irq_ack = 1'b0;
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (irq !== level && n < 10) begin
            n++;
            @(posedge CLOCK_50);
            #2;
        end
        if (irq !== level) begin
            abort_run($sformatf("irq never reached %0b", level));
        end
    endtask

    // Response checker samples mid-cycle where registered outputs are settled
    always @(negedge CLOCK_50) begin
        if (KEY0 && pready) begin
            checks++;
            if (!pend) begin
                report_mismatch("pready with no transfer in flight");
            end else begin
                if (cycle - pend_cycle != 2)
                    report_mismatch($sformatf("pready %0d cycles after setup", cycle - pend_cycle));
                if (prdata !== expected_rdata(pend_addr, pend_write))
                    report_mismatch($sformatf("addr %h prdata %h, expected %h", pend_addr,
                                              prdata, expected_rdata(pend_addr, pend_write)));
                if (pslverr !== expected_err(pend_addr, pend_write))
                    report_mismatch($sformatf("addr %h pslverr %0b", pend_addr, pslverr));
                if (pend_write) store_shadow(pend_addr, pend_data);
                pend = 1'b0;
            end
        end else if (KEY0 && pend && cycle - pend_cycle >= 2) begin
            report_mismatch($sformatf("pready missing for addr %h", pend_addr));
        end
    end

    // Each UART strobe must match one queued write
    always @(negedge CLOCK_50) begin
        if (KEY0 && uart_valid) begin
            checks++;
            if (uart_exp.size() == 0) begin
                report_mismatch("uart_valid without a UART write");
            end else begin
                if (uart_data !== uart_exp[0])
                    report_mismatch($sformatf("uart_data %h, expected %h", uart_data, uart_exp[0]));
                void'(uart_exp.pop_front());
            end
        end
    end

    initial begin
        logic [7:0]        idx;
        logic [data_w-1:0] word;
        void'($urandom(32'h4822));
        CLOCK_50  = 1'b0;
        KEY0      = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        key_valid = 1'b0;
        key_ascii = 8'd0;
        irq_ack   = 1'b0;
        pend      = 1'b0;
        cycle     = 0;
        checks    = 0;
        errors    = 0;
        load_model();
        repeat (16) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;
        // Idle outputs and an empty key latch
        if (pready !== 1'b0 || pslverr !== 1'b0 || irq !== 1'b0 || uart_valid !== 1'b0)
            report_mismatch("outputs not idle after reset");
        if (prdata !== '0)
            report_mismatch($sformatf("prdata %h after reset, expected zero", prdata));
        apb_read(key_addr);
        // Program memory image then a rejected store
        for (int i = 0; i < 16; i++) begin
            apb_read(rom_base | {6'd0, 8'(i), 2'b00});
        end
        apb_write(rom_base | 16'h0008, 32'hdead_beef);
        apb_read(rom_base | 16'h0008);
        // Random data memory traffic
        for (int i = 0; i < 40; i++) begin
            idx  = 8'($urandom);
            word = $urandom;
            apb_write(ram_base | {6'd0, idx, 2'b00}, word);
            idx_list.push_back(idx);
        end
        for (int i = 0; i < 40; i++) begin
            idx = idx_list[$urandom % idx_list.size()];
            apb_read(ram_base | {6'd0, idx, 2'b00});
        end
        // Unmapped, unused I/O and misaligned accesses
        apb_write(ram_base, 32'h1234_5678);
        apb_write(16'h0800, 32'h5555_aaaa);
        apb_read(16'h2000);
        apb_read(16'hfffc);
        apb_read(16'h1008);
        apb_write(16'h100c, 32'h0000_0042);
        apb_write(16'h0402, 32'hffff_ffff);
        apb_read(16'h0006);
        apb_read(ram_base);
        apb_read(rom_base | 16'h0004);
        // Keyboard and interrupt hold
        press_key(8'h41, 1'b0);
        wait_irq(1'b1);
        apb_read(key_addr);
        pulse_ack();
        wait_irq(1'b0);
        press_key(8'h00, 1'b0);
        repeat (3) @(posedge CLOCK_50);
        #2;
        if (irq !== 1'b0) report_mismatch("zero key code raised irq");
        apb_read(key_addr);
        press_key(8'h5a, 1'b0);
        wait_irq(1'b1);
        apb_read(key_addr);
        // Key wins over an acknowledge in the same cycle
        press_key(8'h33, 1'b1);
        if (irq !== 1'b1) report_mismatch("irq dropped when key and ack arrived together");
        apb_read(key_addr);
        pulse_ack();
        wait_irq(1'b0);
        // UART strobes
        for (int i = 0; i < 4; i++) begin
            word = $urandom;
            apb_write(uart_addr, word);
            if (uart_exp.size() != 0) report_mismatch("no uart_valid for a UART write");
            if (uart_valid !== 1'b0) report_mismatch("uart_valid held longer than one cycle");
        end
        apb_read(uart_addr);
        repeat (2) @(posedge CLOCK_50);
        close_run();
    end

endmodule

// ==== rom.hex ====
// Program memory image, one 32-bit word per line in hex
// Line n is the word at byte address 4*n
00000093
00100113
00200193
00308233
004102b3
40418333
0051a023
0001a383
00638463
ff5ff06f
12345678
9abcdef0
a5a5a5a5
5a5a5a5a
0000ffff
ffff0000

// ==== project.f ====
+incdir+tb
source/board_map_pkg.sv
source/bus_pkg.sv
source/bus_decode.sv
source/mem_execute.sv
source/io_execute.sv
source/bus_result.sv
source/board_bus_top.sv
tb/board_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the bus controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f project.f --top-module board_bus_tb -o board_bus_sim

./obj_dir/board_bus_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
